// ==== files.f ====
+incdir+.
uart_pkg.sv
uart_cmd_decode.sv
uart_byte_tx.sv
uart_byte_rx.sv
uart_cmd_sequencer.sv
uart_read_result.sv
uart_ctrl_top.sv
uart_ctrl_properties.sv
tb_uart_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f files.f --top-module tb_uart_ctrl -o sim_uart_ctrl

./obj_dir/sim_uart_ctrl +verilator+error+limit+100 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

// ==== tb_uart_ctrl.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_ctrl;
  import uart_pkg::*;

  localparam int DIV  = `UART_BAUD_DIV;
  localparam int HALF = DIV / 2;
  localparam int GAP  = `UART_GAP_BITS;
  localparam int TMO  = `UART_RX_TIMEOUT;
  localparam int NUM  = 8;

  typedef struct packed {
    cmd_t       cmd;
    logic [7:0] reply;     // Byte the remote device answers with.
    logic       bad_par;
    logic       bad_stop;
    logic       silent;    // Remote device never answers.
    logic       poke;      // Offer a second command while the port is busy.
    rx_status_t exp_status;
  } entry_t;

  logic       clk = 1'b0;
  logic       rst_n;
  cmd_t       cmd_in;
  logic       cmd_vld;
  logic       rx;
  logic       tx;
  logic       cmd_rdy;
  logic [7:0] read_data;
  rx_status_t read_status;
  logic       read_rdy;

  entry_t     table_q [NUM];
  logic [7:0] mon_data [$];
  int         mon_start [$];
  int         cyc = 0;
  int         frames_seen = 0;
  int         exp_frames = 0;
  int         rdy_count = 0;
  int         value_errors = 0;
  int         other_errors = 0;
  logic       rdy_q = 1'b0;

  uart_ctrl_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .rx          (rx),
    .tx          (tx),
    .cmd_rdy     (cmd_rdy),
    .read_data   (read_data),
    .read_status (read_status),
    .read_rdy    (read_rdy)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cyc++;
  end

  task automatic report_mismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
    value_errors++;
    $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("** Error at %0t ns: %s", $time, what);
  endtask

  function automatic entry_t make_entry(input logic wr, input logic [6:0] hi,
                                        input logic bad_par, input logic bad_stop,
                                        input logic silent, input logic poke,
                                        input logic [2:0] exp_status);
    entry_t e;
    e.cmd.wr     = wr;
    e.cmd.hi     = hi;
    e.cmd.lo     = 8'($urandom);
    e.reply      = 8'($urandom);
    e.bad_par    = bad_par;
    e.bad_stop   = bad_stop;
    e.silent     = silent;
    e.poke       = poke;
    e.exp_status = exp_status;
    return e;
  endfunction

  // ####################
  // Line models
  // ####################

  // Called on the first low tx seen at a falling clock edge.
  task automatic decode_frame();
    logic [7:0] d;
    logic       par;
    logic       stp;
    int         start_cyc;
    int         i;
    start_cyc = cyc;
    repeat (HALF - 1) @(negedge clk);
    if (tx !== 1'b0)
    begin
      report_failure("tx start bit did not stay low until mid-bit");
      return;
    end
    for (i = 0; i < 8; i++)
    begin
      repeat (DIV) @(negedge clk);
      d[i] = tx;  // LSB first.
    end
    repeat (DIV) @(negedge clk);
    par = tx;
    repeat (DIV) @(negedge clk);
    stp = tx;
    if (par !== ^d)
      report_mismatch("tx parity bit", {15'd0, par}, {15'd0, ^d});
    if (stp !== 1'b1)
      report_mismatch("tx stop bit", {15'd0, stp}, 16'd1);
    mon_data.push_back(d);
    mon_start.push_back(start_cyc);
    frames_seen++;
  endtask

  always
  begin
    @(negedge clk);
    if (rst_n === 1'b1 && tx === 1'b0)
      decode_frame();
  end

  task automatic drive_reply(input logic [7:0] d, input logic bad_par, input logic bad_stop);
    logic [10:0] frame;
    int          i;
    frame = {~bad_stop, (^d) ^ bad_par, d, 1'b0};
    repeat (2 * DIV) @(posedge clk);  // Let the receiver arm first.
    for (i = 0; i < 11; i++)
    begin
      rx <= frame[i];
      repeat (DIV) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  // Read pulses and the idle level of tx.
  always @(negedge clk)
  begin
    if (read_rdy === 1'b1)
      rdy_count++;
    if (rst_n === 1'b1 && read_rdy === 1'b1 && rdy_q === 1'b1)
      report_failure("read_rdy stayed high for more than one cycle");
    if (rst_n === 1'b1 && cmd_rdy === 1'b1 && tx !== 1'b1)
      report_mismatch("tx while cmd_rdy", {15'd0, tx}, 16'd1);
    rdy_q = read_rdy;
  end

  // ####################
  // Waits
  // ####################

  task automatic wait_frame(input int limit, output logic [7:0] d, output int start_cyc,
                            output bit ok);
    int n;
    n = 0;
    while (mon_data.size() == 0 && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    ok        = (mon_data.size() != 0);
    d         = 8'h00;
    start_cyc = 0;
    if (ok)
    begin
      d         = mon_data.pop_front();
      start_cyc = mon_start.pop_front();
    end
    else
      report_failure("no frame appeared on tx before the timeout");
  endtask

  task automatic wait_cmd_rdy(input int limit);
    int n;
    n = 0;
    while (cmd_rdy !== 1'b1 && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_rdy !== 1'b1)
      report_failure("cmd_rdy did not return high in time");
  endtask

  task automatic wait_read(input int limit, output bit seen);
    int n;
    n = 0;
    while (read_rdy !== 1'b1 && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    seen = (read_rdy === 1'b1);
    if (!seen)
      report_failure("read_rdy did not pulse within the reply timeout");
  endtask

  task automatic issue_cmd(input cmd_t c);
    wait_cmd_rdy(4 * DIV);
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;  // Accepted on this edge.
  endtask

  task automatic poke_while_busy(input cmd_t c);
    @(negedge clk);
    if (cmd_rdy !== 1'b0)
      report_failure("cmd_rdy stayed high after a command was accepted");
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    repeat (3) @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  // ####################
  // Main sequence
  // ####################

  initial
  begin
    entry_t     e;
    logic [7:0] d1;
    logic [7:0] d2;
    logic [7:0] exp_data;
    int         s1;
    int         s2;
    int         rdy_before;
    int         i;
    bit         ok;
    bit         seen;
    rst_n   <= 1'b0;
    cmd_in  <= '0;
    cmd_vld <= 1'b0;
    rx      <= 1'b1;
    void'($urandom(32'ha67b));

    table_q[0] = make_entry(1'b1, 7'h5a, 1'b0, 1'b0, 1'b0, 1'b1, 3'b000);
    table_q[1] = make_entry(1'b0, 7'h21, 1'b0, 1'b0, 1'b0, 1'b1, 3'b000);
    table_q[2] = make_entry(1'b1, 7'h7f, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000);
    table_q[3] = make_entry(1'b0, 7'h03, 1'b1, 1'b0, 1'b0, 1'b0, 3'b100);
    table_q[4] = make_entry(1'b0, 7'h44, 1'b0, 1'b1, 1'b0, 1'b0, 3'b010);
    table_q[5] = make_entry(1'b0, 7'h10, 1'b0, 1'b0, 1'b1, 1'b0, 3'b001);
    table_q[6] = make_entry(1'b0, 7'h66, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000);
    table_q[7] = make_entry(1'b1, 7'h00, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000);

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (tx !== 1'b1)
      report_mismatch("tx after reset", {15'd0, tx}, 16'd1);
    if (cmd_rdy !== 1'b1)
      report_mismatch("cmd_rdy after reset", {15'd0, cmd_rdy}, 16'd1);
    if (read_rdy !== 1'b0)
      report_mismatch("read_rdy after reset", {15'd0, read_rdy}, 16'd0);

    for (i = 0; i < NUM; i++)
    begin
      e          = table_q[i];
      rdy_before = rdy_count;
      issue_cmd(e.cmd);
      if (e.poke)
        poke_while_busy(cmd_t'(~e.cmd));
      wait_frame(13 * DIV, d1, s1, ok);
      if (ok && d1 !== e.cmd[15:8])
        report_mismatch("first frame byte", {8'd0, d1}, {8'd0, e.cmd[15:8]});
      if (e.cmd.wr)
      begin
        exp_frames += 2;
        wait_frame((GAP + 14) * DIV, d2, s2, ok);
        if (ok && d2 !== e.cmd.lo)
          report_mismatch("second frame byte", {8'd0, d2}, {8'd0, e.cmd.lo});
        if (ok && (s2 - (s1 + 11 * DIV)) != GAP * DIV)
          report_mismatch("inter-frame gap", 16'(s2 - (s1 + 11 * DIV)), 16'(GAP * DIV));
        wait_cmd_rdy(2 * DIV);
        if (rdy_count != rdy_before)
          report_failure("read_rdy pulsed during a write");
      end
      else
      begin
        exp_frames += 1;
        fork
          begin
            if (!e.silent)
              drive_reply(e.reply, e.bad_par, e.bad_stop);
          end
          begin
            wait_read((TMO + 2) * DIV, seen);
            if (seen)
            begin
              exp_data = e.silent ? 8'h00 : e.reply;
              if (read_data !== exp_data)
                report_mismatch("read_data", {8'd0, read_data}, {8'd0, exp_data});
              if (read_status !== e.exp_status)
                report_mismatch("read_status", {13'd0, read_status}, {13'd0, e.exp_status});
              wait_cmd_rdy(4);
            end
          end
        join
        if (rdy_count != rdy_before + 1)
          report_mismatch("read_rdy pulses", 16'(rdy_count - rdy_before), 16'd1);
      end
    end

    repeat (4 * DIV) @(negedge clk);  // Room for any frame a dropped command might cause.
    if (frames_seen != exp_frames)
      report_mismatch("frame count", 16'(frames_seen), 16'(exp_frames));

    $display("Summary: %0d value errors, %0d other errors, %0d frames seen",
             value_errors, other_errors, frames_seen);
    if (value_errors + other_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== uart_byte_rx.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_byte_rx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  input  logic                 rx_arm,
  output uart_pkg::rx_result_t rx_res,
  output logic                 rx_valid
);
  import uart_pkg::*;

  localparam int DIV  = `UART_BAUD_DIV;
  localparam int HALF = DIV / 2;
  localparam int TMO  = `UART_RX_TIMEOUT;
  localparam int BW   = $clog2(DIV);
  localparam int TW   = $clog2(TMO + 1);

  typedef enum logic [1:0] {
    R_IDLE,
    R_HUNT,
    R_RECV
  } rx_state_t;

  rx_state_t     state;
  logic          rx_s1;
  logic          rx_s2;
  logic          rx_d;
  logic [BW-1:0] baud_cnt;
  logic [TW-1:0] tmo_bits;
  logic [3:0]    bit_idx;
  logic [7:0]    shift_q;
  logic          par_q;
  logic          mid;
  logic          stop_hit;
  logic          tmo_hit;
  rx_status_t    status;

  assign mid      = (state == R_RECV) && (baud_cnt == BW'(HALF - 1));
  assign stop_hit = mid && (bit_idx == 4'd10);
  assign tmo_hit  = (state == R_HUNT) && (baud_cnt == BW'(DIV - 1)) &&
                    (tmo_bits == TW'(TMO - 1));

  // ####################
  // Line tracking
  // ####################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1    <= 1'b1;
      rx_s2    <= 1'b1;
      rx_d     <= 1'b1;
      state    <= R_IDLE;
      baud_cnt <= '0;
      tmo_bits <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
      case (state)
        R_IDLE:
        begin
          if (rx_arm)
          begin
            state    <= R_HUNT;
            baud_cnt <= '0;
            tmo_bits <= '0;
          end
        end
        R_HUNT:
        begin
          if (rx_d && !rx_s2)
          begin
            state    <= R_RECV;  // Falling edge marks the start bit.
            baud_cnt <= '0;
            bit_idx  <= '0;
          end
          else if (tmo_hit)
            state <= R_IDLE;
          else if (baud_cnt == BW'(DIV - 1))
          begin
            baud_cnt <= '0;
            tmo_bits <= tmo_bits + 1'b1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        R_RECV:
        begin
          if (stop_hit)
            state <= R_IDLE;
          else if (mid && (bit_idx == 4'd0) && rx_s2)
          begin
            state    <= R_HUNT;  // Glitch, not a real start bit.
            baud_cnt <= '0;
          end
          else if (baud_cnt == BW'(DIV - 1))
          begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 4'd1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid && (bit_idx >= 4'd1) && (bit_idx <= 4'd8))
      shift_q <= {rx_s2, shift_q[7:1]};  // LSB arrives first.
    if (mid && (bit_idx == 4'd9))
      par_q <= rx_s2;
  end

  // ####################
  // Result
  // ####################

  always_comb
  begin
    status.parity_err = stop_hit && (even_parity(shift_q) != par_q);
    status.frame_err  = stop_hit && !rx_s2;
    status.timeout    = tmo_hit;
  end

  assign rx_valid = stop_hit || tmo_hit;
  assign rx_res   = '{data: (stop_hit ? shift_q : 8'h00), status: status};

endmodule

// ==== uart_byte_tx.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_byte_tx (
  input  logic              clk,
  input  logic              rst_n,
  input  uart_pkg::tx_req_t tx_req,
  output logic              tx,
  output logic              tx_done
);
  import uart_pkg::*;

  localparam int DIV = `UART_BAUD_DIV;
  localparam int BW  = $clog2(DIV);

  logic          busy;
  logic [BW-1:0] baud_cnt;
  logic [3:0]    bit_idx;
  logic [9:0]    shift_q;  // Data, parity and stop still to go.
  logic          load;
  logic          bit_end;

  assign load    = !busy && tx_req.start;
  assign bit_end = busy && (baud_cnt == BW'(DIV - 1));
  assign tx_done = bit_end && (bit_idx == 4'd10);  // Last clock of the stop bit.

  // ####################
  // Bit timing
  // ####################

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else if (load)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b0;  // Start bit.
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == 4'd10)
        busy <= 1'b0;
      else
      begin
        bit_idx <= bit_idx + 4'd1;
        tx      <= shift_q[0];
      end
    end
    else if (busy)
      baud_cnt <= baud_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (load)
      shift_q <= {1'b1, even_parity(tx_req.data), tx_req.data};
    else if (bit_end)
      shift_q <= {1'b1, shift_q[9:1]};
  end

endmodule

// ==== uart_cmd_decode.sv ====
`timescale 1ns/1ps

module uart_cmd_decode (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_pkg::cmd_t     cmd_in,
  input  logic               cmd_vld,
  input  logic               done,
  output logic               cmd_rdy,
  output logic               go,
  output uart_pkg::uart_op_t op,
  output uart_pkg::cmd_t     cmd
);
  import uart_pkg::*;

  logic busy;
  logic accept;

  assign cmd_rdy = !busy;
  assign accept  = cmd_vld && !busy;  // A command while busy is simply dropped.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy <= 1'b0;
      go   <= 1'b0;
    end
    else
    begin
      go <= accept;
      if (accept)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;  // Port reopens the cycle after done.
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd <= cmd_in;
  end

  assign op = cmd.wr ? op_write : op_read;  // Held stable for the whole operation.

endmodule

// ==== uart_cmd_sequencer.sv ====
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_cmd_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               go,
  input  uart_pkg::uart_op_t op,
  input  uart_pkg::cmd_t     cmd,
  input  logic               tx_done,
  input  logic               rx_valid,
  output uart_pkg::tx_req_t  tx_req,
  output logic               rx_arm,
  output logic               done
);
  import uart_pkg::*;

  localparam int DIV = `UART_BAUD_DIV;
  localparam int GAP = `UART_GAP_BITS;
  localparam int BW  = $clog2(DIV);
  localparam int GW  = $clog2(GAP + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_GAP,
    S_SEND_LO,
    S_WAIT_RX
  } seq_state_t;

  seq_state_t    state;
  logic [BW-1:0] baud_cnt;
  logic [GW-1:0] gap_bits;
  logic          gap_end;

  // Two cycles early, since the request and the transmitter each add one.
  assign gap_end = (gap_bits == GW'(GAP - 1)) && (baud_cnt == BW'(DIV - 2));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      baud_cnt <= '0;
      gap_bits <= '0;
      tx_req   <= '0;
      rx_arm   <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      tx_req.start <= 1'b0;
      rx_arm       <= 1'b0;
      done         <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (go)
          begin
            tx_req <= '{start: 1'b1, data: {cmd.wr, cmd.hi}};
            state  <= S_SEND_HI;
          end
        end
        S_SEND_HI:
        begin
          if (tx_done && (op == op_write))
          begin
            state    <= S_GAP;
            baud_cnt <= '0;
            gap_bits <= '0;
          end
          else if (tx_done)
          begin
            rx_arm <= 1'b1;
            state  <= S_WAIT_RX;
          end
        end
        S_GAP:
        begin
          if (gap_end)
          begin
            tx_req <= '{start: 1'b1, data: cmd.lo};
            state  <= S_SEND_LO;
          end
          else if (baud_cnt == BW'(DIV - 1))
          begin
            baud_cnt <= '0;
            gap_bits <= gap_bits + 1'b1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        S_SEND_LO:
        begin
          if (tx_done)
          begin
            done  <= 1'b1;
            state <= S_IDLE;
          end
        end
        S_WAIT_RX:
        begin
          if (rx_valid)
          begin
            done  <= 1'b1;  // Reply or timeout, either way the read is over.
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// ####################
// Serial timing
// ####################

// Clocks per bit period.
`define UART_BAUD_DIV 16

`define UART_GAP_BITS 4     // Idle bit periods between the two write frames.
`define UART_RX_TIMEOUT 32  // Bit periods to wait for a reply start bit.

`endif

// ==== uart_ctrl_properties.sv ====
`timescale 1ns/1ps

module uart_ctrl_properties (
  input logic           clk,
  input logic           rst_n,
  input uart_pkg::cmd_t cmd_in,
  input logic           cmd_vld,
  input logic           cmd_rdy,
  input logic           tx,
  input logic           read_rdy
);

  logic wr_pend;  // An accepted write has not finished yet.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wr_pend <= 1'b0;
    else if (cmd_vld && cmd_rdy)
      wr_pend <= cmd_in.wr;
    else if (cmd_rdy)
      wr_pend <= 1'b0;
  end

  // ####################
  // Port rules
  // ####################

  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx is low while cmd_rdy is high");

  a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy lasted more than one cycle");

  a_no_read_on_write: assert property (@(posedge clk) disable iff (!rst_n)
                                       $rose(read_rdy) |-> !wr_pend)
    else $error("read_rdy rose while a write was pending");

endmodule

bind uart_ctrl_top uart_ctrl_properties u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_in   (cmd_in),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

// ==== uart_ctrl_top.sv ====
`timescale 1ns/1ps

module uart_ctrl_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::cmd_t       cmd_in,
  input  logic                 cmd_vld,
  input  logic                 rx,
  output logic                 tx,
  output logic                 cmd_rdy,
  output logic [7:0]           read_data,
  output uart_pkg::rx_status_t read_status,
  output logic                 read_rdy
);
  import uart_pkg::*;

  logic       go;
  uart_op_t   op;
  cmd_t       cmd;
  logic       done;
  tx_req_t    tx_req;
  logic       tx_done;
  logic       rx_arm;
  rx_result_t rx_res;
  logic       rx_valid;

  // ####################
  // Decode and sequence
  // ####################

  uart_cmd_decode u_decode (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .done    (done),
    .cmd_rdy (cmd_rdy),
    .go      (go),
    .op      (op),
    .cmd     (cmd)
  );

  uart_cmd_sequencer u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .go       (go),
    .op       (op),
    .cmd      (cmd),
    .tx_done  (tx_done),
    .rx_valid (rx_valid),
    .tx_req   (tx_req),
    .rx_arm   (rx_arm),
    .done     (done)
  );

  // ####################
  // Serial line
  // ####################

  uart_byte_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_req  (tx_req),
    .tx      (tx),
    .tx_done (tx_done)
  );

  uart_byte_rx u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_arm   (rx_arm),
    .rx_res   (rx_res),
    .rx_valid (rx_valid)
  );

  uart_read_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .rx_res      (rx_res),
    .rx_valid    (rx_valid),
    .read_data   (read_data),
    .read_status (read_status),
    .read_rdy    (read_rdy)
  );

endmodule

// ==== uart_pkg.sv ====
package uart_pkg;

  // ####################
  // Command and operation
  // ####################

  typedef struct packed {
    logic       wr;  // Set for a write command.
    logic [6:0] hi;
    logic [7:0] lo;
  } cmd_t;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } uart_op_t;

  // ####################
  // Serial side
  // ####################

  typedef struct packed {
    logic       start;  // One-cycle strobe that launches a frame.
    logic [7:0] data;
  } tx_req_t;

  typedef struct packed {
    logic parity_err;
    logic frame_err;  // Stop bit sampled low.
    logic timeout;
  } rx_status_t;

  typedef struct packed {
    logic [7:0] data;
    rx_status_t status;
  } rx_result_t;

  // Even parity bit, used by both the transmitter and the receiver check.
  function automatic logic even_parity(input logic [7:0] d);
    return ^d;
  endfunction

endpackage

// ==== uart_read_result.sv ====
`timescale 1ns/1ps

module uart_read_result (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::rx_result_t rx_res,
  input  logic                 rx_valid,
  output logic [7:0]           read_data,
  output uart_pkg::rx_status_t read_status,
  output logic                 read_rdy
);
  import uart_pkg::*;

  rx_result_t res_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_rdy <= 1'b0;
    else
      read_rdy <= rx_valid;
  end

  // Held until the next read completes.
  always_ff @(posedge clk)
  begin
    if (rx_valid)
      res_q <= rx_res;
  end

  assign read_data   = res_q.data;
  assign read_status = res_q.status;

endmodule
